// ==== Makefile ====
TOP := tb_soc_interconnect

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module soc_interconnect

obj_dir/V$(TOP): sim.f
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== design/addr_map_pkg.sv ====
`default_nettype none

`include "tcdm_consts.svh"

package addr_map_pkg;

    // Target slots 0 to 3 are banks, 4 and 5 the contiguous slaves
    // The last slot is the error target inside the interconnect
    typedef logic [$clog2(`TCDM_NUM_TARGETS)-1:0] target_idx_t;

    // Index of a core on the master side
    typedef logic [$clog2(`TCDM_NUM_MASTERS)-1:0] master_idx_t;

    // Coarse region an address falls into before the slot is picked
    typedef enum logic [1:0] {
        REGION_INTLV,
        REGION_CONTIG,
        REGION_NONE
    } region_e;

    //////////////////////////////////////////////////////////////////////
    // Region helpers
    //////////////////////////////////////////////////////////////////////

    // First target slot that belongs to a contiguous slave
    localparam target_idx_t CONTIG_FIRST_TGT = target_idx_t'(`TCDM_NUM_BANKS);

    // Slot of the error target
    localparam target_idx_t ERROR_TGT = target_idx_t'(`TCDM_ERROR_TARGET);

endpackage

`default_nettype wire

// ==== design/soc_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_consts.svh"

module soc_interconnect (
    input  wire                            clk_i,
    input  wire                            rst_i,
    // Core side
    input  wire tcdm_bus_pkg::tcdm_req_t      mst_req_i [`TCDM_NUM_MASTERS],
    output logic [`TCDM_NUM_MASTERS-1:0]      mst_gnt_o,
    output tcdm_bus_pkg::tcdm_rsp_t           mst_rsp_o [`TCDM_NUM_MASTERS],
    // Memory side, banks first and then the contiguous slaves
    output tcdm_bus_pkg::tcdm_req_t           tgt_req_o [`TCDM_NUM_TGT_PORTS],
    input  wire [`TCDM_NUM_TGT_PORTS-1:0]     tgt_gnt_i,
    input  wire tcdm_bus_pkg::tcdm_data_t     tgt_rdata_i [`TCDM_NUM_TGT_PORTS]
);

    import addr_map_pkg::*;

    // Slot picked for each core in the request cycle
    target_idx_t mst_tgt [`TCDM_NUM_MASTERS];

    //////////////////////////////////////////////////////////////////////
    // Decode, arbitrate and route back
    //////////////////////////////////////////////////////////////////////

    // Address map lookup, purely combinational
    tcdm_addr_decoder u_decoder (
        .clk_i,
        .rst_i,
        .mst_req_i (mst_req_i),
        .mst_tgt_o (mst_tgt)
    );

    // Grants come back in the same cycle as the request
    // The winner index per port is left open here and can be probed on the arbiter
    tcdm_target_arbiter u_arbiter (
        .clk_i,
        .rst_i,
        .mst_req_i (mst_req_i),
        .mst_tgt_i (mst_tgt),
        .tgt_gnt_i (tgt_gnt_i),
        .tgt_req_o (tgt_req_o),
        .mst_gnt_o (mst_gnt_o),
        .mst_win_o ()
    );

    // Responses follow each grant by exactly one cycle
    tcdm_resp_router u_router (
        .clk_i,
        .rst_i,
        .mst_gnt_i   (mst_gnt_o),
        .mst_tgt_i   (mst_tgt),
        .tgt_rdata_i (tgt_rdata_i),
        .mst_rsp_o   (mst_rsp_o)
    );

endmodule

`default_nettype wire

// ==== design/tcdm_addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_addr_decoder (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire tcdm_bus_pkg::tcdm_req_t mst_req_i [`TCDM_NUM_MASTERS],
    output addr_map_pkg::target_idx_t mst_tgt_o [`TCDM_NUM_MASTERS]
);

    import tcdm_bus_pkg::*;
    import addr_map_pkg::*;

    // Bank select width follows from the bank count
    localparam int unsigned BANK_SEL_W = $clog2(`TCDM_NUM_BANKS);
    // Shift that turns a contiguous offset into a window number
    localparam int unsigned CONTIG_SHIFT = $clog2(`TCDM_CONTIG_SIZE);

    // Region limits, the upper ones are exclusive
    localparam tcdm_addr_t INTLV_END = `TCDM_INTLV_BASE + `TCDM_INTLV_SIZE;
    localparam tcdm_addr_t CONTIG_END = `TCDM_CONTIG_BASE
                                      + (`TCDM_NUM_CONTIG * `TCDM_CONTIG_SIZE);

    //////////////////////////////////////////////////////////////////////
    // Per-core address decode
    //////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++) begin : gen_decode
        // The restricted core is told apart at elaboration time
        localparam bit INTLV_ONLY = (m == `TCDM_INTLV_ONLY_MASTER);

        tcdm_addr_t addr;
        tcdm_addr_t contig_off;
        region_e    region;

        assign addr       = mst_req_i[m].addr;
        assign contig_off = addr - `TCDM_CONTIG_BASE;

        // Classify the address into one of the coarse regions
        always_comb begin
            if ((addr >= `TCDM_INTLV_BASE) && (addr < INTLV_END)) begin
                region = REGION_INTLV;
            end else if ((addr >= `TCDM_CONTIG_BASE) && (addr < CONTIG_END)) begin
                region = REGION_CONTIG;
            end else begin
                region = REGION_NONE;
            end
        end

        // Pick the target slot inside the region
        always_comb begin
            mst_tgt_o[m] = ERROR_TGT;
            unique case (region)
                REGION_INTLV: begin
                    // Consecutive words walk through the banks
                    mst_tgt_o[m] = target_idx_t'(addr[`TCDM_BANK_SEL_LSB +: BANK_SEL_W]);
                end
                REGION_CONTIG: begin
                    // The restricted core falls through to the error target here
                    if (!INTLV_ONLY) begin
                        mst_tgt_o[m] = CONTIG_FIRST_TGT
                                     + target_idx_t'(contig_off >> CONTIG_SHIFT);
                    end
                end
                default: begin
                    mst_tgt_o[m] = ERROR_TGT;
                end
            endcase
        end

        // An active request never leaves the decoder without a valid slot
        a_tgt_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
            mst_req_i[m].req |-> (mst_tgt_o[m] < target_idx_t'(`TCDM_NUM_TARGETS)));
    end

endmodule

`default_nettype wire

// ==== design/tcdm_bus_pkg.sv ====
`default_nettype none

package tcdm_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus word types
    //////////////////////////////////////////////////////////////////////

    // Byte address as issued by a core
    typedef logic [31:0] tcdm_addr_t;
    // One bus word, used for write and read data alike
    typedef logic [31:0] tcdm_data_t;
    // One enable bit per byte lane of a word
    typedef logic [3:0]  tcdm_be_t;

    //////////////////////////////////////////////////////////////////////
    // Request and response bundles
    //////////////////////////////////////////////////////////////////////

    // Request as driven by a requester towards the interconnect
    // The requester keeps all fields stable until the grant arrives
    typedef struct packed {
        logic       req;
        // Low for a write and high for a read, as on the TCDM bus
        logic       wen;
        tcdm_addr_t addr;
        tcdm_be_t   be;
        tcdm_data_t wdata;
    } tcdm_req_t;

    // Response returned to a core one cycle after its grant
    typedef struct packed {
        logic       r_valid;
        // Set when the access hit the error target
        logic       r_opc;
        // Only meaningful for reads, writes still get a response beat
        tcdm_data_t r_rdata;
    } tcdm_rsp_t;

endpackage

`default_nettype wire

// ==== design/tcdm_consts.svh ====
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Port counts
//////////////////////////////////////////////////////////////////////

// Cores attached to the interconnect on the master side
`define TCDM_NUM_MASTERS 3
// Word-interleaved memory banks
`define TCDM_NUM_BANKS 4
// Contiguous slaves, each owning one fixed window
`define TCDM_NUM_CONTIG 2
// External target ports are the banks followed by the contiguous slaves
`define TCDM_NUM_TGT_PORTS 6
// The internal error target adds one more arbitration slot
`define TCDM_NUM_TARGETS 7
// Index of the error target, right after the external ports
`define TCDM_ERROR_TARGET 6

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

// Interleaved region covers 64 KiB spread over all banks
`define TCDM_INTLV_BASE 32'h1C10_0000
`define TCDM_INTLV_SIZE 32'h0001_0000
// Contiguous slaves sit back to back from this base
`define TCDM_CONTIG_BASE 32'h1C00_0000
`define TCDM_CONTIG_SIZE 32'h0000_8000
// Lowest byte-address bit that selects the bank, so word 0 goes to bank 0
`define TCDM_BANK_SEL_LSB 2

// This core may only reach the interleaved region
`define TCDM_INTLV_ONLY_MASTER 2
// Read data returned by the error target
`define TCDM_ERROR_WORD 32'hBADA_CCE5

`endif

// ==== design/tcdm_resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_resp_router (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire [`TCDM_NUM_MASTERS-1:0]        mst_gnt_i,
    input  wire addr_map_pkg::target_idx_t     mst_tgt_i [`TCDM_NUM_MASTERS],
    input  wire tcdm_bus_pkg::tcdm_data_t      tgt_rdata_i [`TCDM_NUM_TGT_PORTS],
    output tcdm_bus_pkg::tcdm_rsp_t            mst_rsp_o [`TCDM_NUM_MASTERS]
);

    import addr_map_pkg::*;

    // One response is owed in the next cycle for every granted core
    logic [`TCDM_NUM_MASTERS-1:0] rsp_pending_q;
    // Slot that served the grant, kept until the response goes out
    target_idx_t                  rsp_tgt_q [`TCDM_NUM_MASTERS];

    //////////////////////////////////////////////////////////////////////
    // Grant capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_pending_q <= '0;
        end else begin
            rsp_pending_q <= mst_gnt_i;
        end
    end

    for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++) begin : gen_route
        // The slot only matters while a response is pending
        always_ff @(posedge clk_i) begin
            if (mst_gnt_i[m]) begin
                rsp_tgt_q[m] <= mst_tgt_i[m];
            end
        end

        //////////////////////////////////////////////////////////////////
        // Response mux
        //////////////////////////////////////////////////////////////////

        // Targets deliver their word in the cycle after the grant
        // and the error target answers right here without any storage
        always_comb begin
            mst_rsp_o[m].r_valid = rsp_pending_q[m];
            mst_rsp_o[m].r_opc   = 1'b0;
            mst_rsp_o[m].r_rdata = '0;
            if (rsp_pending_q[m]) begin
                if (rsp_tgt_q[m] == ERROR_TGT) begin
                    mst_rsp_o[m].r_opc   = 1'b1;
                    mst_rsp_o[m].r_rdata = `TCDM_ERROR_WORD;
                end else begin
                    mst_rsp_o[m].r_rdata = tgt_rdata_i[rsp_tgt_q[m]];
                end
            end
        end

        // A response always traces back to a grant one cycle earlier
        a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
            !mst_gnt_i[m] |=> !mst_rsp_o[m].r_valid);
    end

endmodule

`default_nettype wire

// ==== design/tcdm_target_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_consts.svh"

module tcdm_target_arbiter (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire tcdm_bus_pkg::tcdm_req_t    mst_req_i [`TCDM_NUM_MASTERS],
    input  wire addr_map_pkg::target_idx_t  mst_tgt_i [`TCDM_NUM_MASTERS],
    input  wire [`TCDM_NUM_TGT_PORTS-1:0]   tgt_gnt_i,
    output tcdm_bus_pkg::tcdm_req_t         tgt_req_o [`TCDM_NUM_TGT_PORTS],
    output logic [`TCDM_NUM_MASTERS-1:0]    mst_gnt_o,
    output addr_map_pkg::master_idx_t       mst_win_o [`TCDM_NUM_TGT_PORTS]
);

    import addr_map_pkg::*;

    localparam master_idx_t LAST_MST = master_idx_t'(`TCDM_NUM_MASTERS - 1);

    // Requests seen by each target, one bit per core
    logic [`TCDM_NUM_MASTERS-1:0] req_vec [`TCDM_NUM_TARGETS];
    // Round-robin pointer of each target, the core with top priority
    master_idx_t                  rr_ptr [`TCDM_NUM_TARGETS];
    master_idx_t                  win_idx [`TCDM_NUM_TARGETS];
    logic [`TCDM_NUM_TARGETS-1:0] win_valid;
    // Grant of every slot, the error target never stalls
    logic [`TCDM_NUM_TARGETS-1:0] tgt_gnt;
    // Grant of each core split up by target
    logic [`TCDM_NUM_TARGETS-1:0] gnt_hit [`TCDM_NUM_MASTERS];

    assign tgt_gnt = {1'b1, tgt_gnt_i};

    //////////////////////////////////////////////////////////////////////
    // Round-robin pick per target
    //////////////////////////////////////////////////////////////////////

    for (genvar t = 0; t < `TCDM_NUM_TARGETS; t++) begin : gen_target
        always_comb begin
            for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
                req_vec[t][m] = mst_req_i[m].req && (mst_tgt_i[m] == target_idx_t'(t));
            end
        end

        // Walk once around the cores starting at the pointer
        always_comb begin
            master_idx_t cand;
            win_valid[t] = 1'b0;
            win_idx[t]   = rr_ptr[t];
            cand         = rr_ptr[t];
            for (int k = 0; k < `TCDM_NUM_MASTERS; k++) begin
                if (!win_valid[t] && req_vec[t][cand]) begin
                    win_valid[t] = 1'b1;
                    win_idx[t]   = cand;
                end
                cand = (cand == LAST_MST) ? '0 : cand + 1'b1;
            end
        end

        // The winner drops to lowest priority only once it is really granted
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                rr_ptr[t] <= '0;
            end else if (win_valid[t] && tgt_gnt[t]) begin
                rr_ptr[t] <= (win_idx[t] == LAST_MST) ? '0 : win_idx[t] + 1'b1;
            end
        end

        // Only external slots own a request port
        if (t < `TCDM_NUM_TGT_PORTS) begin : gen_port
            // The port request never looks at the port grant
            always_comb begin
                tgt_req_o[t] = '0;
                if (win_valid[t]) begin
                    tgt_req_o[t] = mst_req_i[win_idx[t]];
                end
            end
            assign mst_win_o[t] = win_idx[t];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Grants back to the cores
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
            for (int t = 0; t < `TCDM_NUM_TARGETS; t++) begin
                gnt_hit[m][t] = win_valid[t] && tgt_gnt[t]
                             && (win_idx[t] == master_idx_t'(m));
            end
            mst_gnt_o[m] = |gnt_hit[m];
        end
    end

    for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++) begin : gen_chk
        // A core is never served by two targets in the same cycle
        a_single_target: assert property (@(posedge clk_i) disable iff (rst_i)
            $onehot0(gnt_hit[m]));
        // No grant reaches a core that is not asking
        a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
            mst_gnt_o[m] |-> mst_req_i[m].req);
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/tcdm_bus_pkg.sv
design/addr_map_pkg.sv
design/tcdm_addr_decoder.sv
design/tcdm_target_arbiter.sv
design/tcdm_resp_router.sv
design/soc_interconnect.sv
verif/tb_bank_model.sv
verif/tb_soc_interconnect.sv

// ==== verif/tb_bank_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bank_model #(
    parameter logic [31:0] SEED = 32'hc228
) (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire tcdm_bus_pkg::tcdm_req_t req_i,
    input  wire                          stall_en_i,
    output logic                         gnt_o,
    output tcdm_bus_pkg::tcdm_data_t     rdata_o
);

    import tcdm_bus_pkg::*;

    // Word storage keyed by the word address, filled lazily
    tcdm_data_t mem [logic [29:0]];
    logic [31:0] lcg_q;
    // Registered stall so the grant stays combinational on the request
    logic        stall_q;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words read back a pattern built from the whole address
    function automatic tcdm_data_t fill_word(input tcdm_addr_t a);
        return {a[31:2], 2'b00} ^ 32'hA5A5_0F0F;
    endfunction

    assign gnt_o = req_i.req && !stall_q;

    always_ff @(posedge clk_i) begin
        tcdm_data_t word;
        if (rst_i) begin
            lcg_q   <= SEED;
            stall_q <= 1'b0;
            rdata_o <= '0;
        end else begin
            lcg_q   <= lcg_step(lcg_q);
            // Roughly one cycle in four is stalled when enabled
            stall_q <= stall_en_i && (lcg_q[17:16] == 2'b00);
            if (gnt_o) begin
                word = mem.exists(req_i.addr[31:2]) ? mem[req_i.addr[31:2]]
                                                    : fill_word(req_i.addr);
                if (!req_i.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.be[b]) word[8*b +: 8] = req_i.wdata[8*b +: 8];
                    end
                    mem[req_i.addr[31:2]] = word;
                end
                rdata_o <= word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_soc_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_consts.svh"

module tb_soc_interconnect;

    import tcdm_bus_pkg::*;

    // Transactions over all tests and the worst wait for one of them
    localparam int NUM_TXN = 2 * 16 + 2 * 3 + 2 + 3 * 6 + 3 * 20;
    localparam int MAX_WAIT_CYC = 40;

    typedef struct packed {
        logic        chk_data;
        logic        opc;
        logic [31:0] data;
        logic [31:0] cyc;
    } exp_t;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic stall_en = 1'b0;
    logic only_one = 1'b0;
    logic [31:0] cycle = '0;
    logic [31:0] rnd = 32'hc228;
    tcdm_req_t mst_req [`TCDM_NUM_MASTERS];
    logic [`TCDM_NUM_MASTERS-1:0] mst_gnt;
    tcdm_rsp_t mst_rsp [`TCDM_NUM_MASTERS];
    tcdm_req_t tgt_req [`TCDM_NUM_TGT_PORTS];
    logic [`TCDM_NUM_TGT_PORTS-1:0] tgt_gnt;
    tcdm_data_t tgt_rdata [`TCDM_NUM_TGT_PORTS];
    tcdm_data_t shadow [logic [29:0]];
    exp_t exp_q [`TCDM_NUM_MASTERS][$];
    int rr_model [`TCDM_NUM_TARGETS];

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    soc_interconnect uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mst_req_i   (mst_req),
        .mst_gnt_o   (mst_gnt),
        .mst_rsp_o   (mst_rsp),
        .tgt_req_o   (tgt_req),
        .tgt_gnt_i   (tgt_gnt),
        .tgt_rdata_i (tgt_rdata)
    );

    for (genvar p = 0; p < `TCDM_NUM_TGT_PORTS; p++) begin : gen_mem
        tb_bank_model #(.SEED(32'hc228 + 32'(p) * 32'd97)) u_mem (
            .clk_i      (clk_i),
            .rst_i      (rst_i),
            .req_i      (tgt_req[p]),
            .stall_en_i (stall_en),
            .gnt_o      (tgt_gnt[p]),
            .rdata_o    (tgt_rdata[p])
        );
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model of the address map and memory contents
    ////////////////////////////////////////////////////////////////////

    function automatic int ref_target(input int m, input logic [31:0] a);
        if (a >= `TCDM_INTLV_BASE && a < `TCDM_INTLV_BASE + `TCDM_INTLV_SIZE)
            return int'(a[3:2]);
        if (m != `TCDM_INTLV_ONLY_MASTER && a >= `TCDM_CONTIG_BASE
            && a < `TCDM_CONTIG_BASE + 2 * `TCDM_CONTIG_SIZE)
            return 4 + int'((a - `TCDM_CONTIG_BASE) / `TCDM_CONTIG_SIZE);
        return 6;
    endfunction

    // Applies the access to the shadow memory and returns the expected beat
    function automatic exp_t ref_access(input int m, input tcdm_req_t r);
        exp_t e;
        logic [31:0] w;
        e = '0;
        e.cyc = cycle;
        if (ref_target(m, r.addr) == 6) begin
            e.chk_data = 1'b1;
            e.opc = 1'b1;
            e.data = `TCDM_ERROR_WORD;
            return e;
        end
        w = shadow.exists(r.addr[31:2]) ? shadow[r.addr[31:2]]
                                        : ({r.addr[31:2], 2'b00} ^ 32'hA5A5_0F0F);
        if (!r.wen) begin
            for (int b = 0; b < 4; b++) if (r.be[b]) w[8*b +: 8] = r.wdata[8*b +: 8];
            shadow[r.addr[31:2]] = w;
        end
        e.chk_data = r.wen;
        e.data = w;
        return e;
    endfunction

    // Drives one request at 2 ns after the edge and holds it until granted
    task automatic issue(input int m, input logic wen, input logic [31:0] addr,
                         input logic [3:0] be, input logic [31:0] wdata, input string name);
        int t;
        mst_req[m] = '{req: 1'b1, wen: wen, addr: addr, be: be, wdata: wdata};
        t = ref_target(m, addr);
        forever begin
            @(negedge clk_i);
            if (mst_gnt[m]) break;
        end
        if (t < 6) begin
            check_val({name, " port req"}, 1, tgt_req[t].req);
            check_val({name, " port addr"}, addr, tgt_req[t].addr);
        end else if (only_one) begin
            for (int p = 0; p < 6; p++) check_val({name, " idle port"}, 0, tgt_req[p].req);
        end
        exp_q[m].push_back(ref_access(m, mst_req[m]));
        @(posedge clk_i);
        #2;
        mst_req[m].req = 1'b0;
    endtask

    // Compares every response beat against the expected queue of its core
    always @(negedge clk_i) begin
        exp_t e;
        if (!rst_i) begin
            for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
                if (mst_rsp[m].r_valid) begin
                    if (exp_q[m].size() == 0) begin
                        $display("Core %0d got a response it never asked for", m);
                        $display("TEST RESULT: FAIL");
                        $fatal(1);
                    end
                    e = exp_q[m].pop_front();
                    check_val($sformatf("rsp timing m%0d", m), e.cyc + 1, cycle);
                    check_val($sformatf("rsp opc m%0d", m), e.opc, mst_rsp[m].r_opc);
                    if (e.chk_data) begin
                        check_val($sformatf("rsp data m%0d", m), e.data,
                                  mst_rsp[m].r_rdata);
                    end
                end
            end
        end
    end

    // Round-robin order and back-pressure seen from every target
    always @(negedge clk_i) begin
        int winner;
        int ngnt;
        int got;
        int c;
        if (!rst_i) begin
            for (int t = 0; t < `TCDM_NUM_TARGETS; t++) begin
                winner = -1;
                ngnt = 0;
                got = -1;
                for (int k = 0; k < `TCDM_NUM_MASTERS; k++) begin
                    c = (rr_model[t] + k) % `TCDM_NUM_MASTERS;
                    if (winner < 0 && mst_req[c].req && ref_target(c, mst_req[c].addr) == t)
                        winner = c;
                end
                for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
                    if (mst_gnt[m] && ref_target(m, mst_req[m].addr) == t) begin
                        ngnt++;
                        got = m;
                    end
                end
                if ((t < 6 && !tgt_gnt[t]) || winner < 0) begin
                    check_val($sformatf("no grant tgt%0d", t), 0, ngnt);
                end else begin
                    check_val($sformatf("one grant tgt%0d", t), 1, ngnt);
                    check_val($sformatf("rr winner tgt%0d", t), winner, got);
                    rr_model[t] = (winner + 1) % `TCDM_NUM_MASTERS;
                end
            end
        end
    end

    task automatic check_idle(input string name);
        check_val({name, " gnt"}, 0, mst_gnt);
        for (int m = 0; m < `TCDM_NUM_MASTERS; m++)
            check_val({name, " r_valid"}, 0, mst_rsp[m].r_valid);
        for (int p = 0; p < 6; p++) check_val({name, " port req"}, 0, tgt_req[p].req);
    endtask

    // Every core writes and then reads back the same words of one bank
    task automatic hammer_bank(input int m);
        for (int k = 0; k < 6; k++)
            issue(m, k[0], `TCDM_INTLV_BASE + 32'h100 + 16 * (k / 2), 4'hF,
                  32'(m * 256 + k), "contend");
    endtask

    // Random mix of reads and writes under grant stalls
    task automatic random_traffic(input int m);
        logic [31:0] a;
        for (int k = 0; k < 20; k++) begin
            rnd = lcg_next(rnd);
            if (m == `TCDM_INTLV_ONLY_MASTER || rnd[20]) begin
                a = `TCDM_INTLV_BASE + {rnd[15:10], 2'b00};
            end else begin
                a = `TCDM_CONTIG_BASE + (rnd[21] ? `TCDM_CONTIG_SIZE : 0)
                  + {rnd[13:10], 2'b00};
            end
            issue(m, rnd[22], a, rnd[27:24] | 4'h1, lcg_next(rnd), "random");
        end
    endtask

    initial begin
        #(NUM_TXN * MAX_WAIT_CYC * 40);
        $display("Watchdog expired before all transactions completed");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        for (int m = 0; m < `TCDM_NUM_MASTERS; m++) mst_req[m] = '0;
        for (int t = 0; t < `TCDM_NUM_TARGETS; t++) rr_model[t] = 0;
        repeat (5) begin
            @(negedge clk_i);
            check_idle("reset");
        end
        @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_idle("after reset");
        @(posedge clk_i);
        #2;
        // Consecutive interleaved words walk across the banks
        for (int k = 0; k < 16; k++) begin
            issue(0, 1'b0, `TCDM_INTLV_BASE + 4 * k, 4'hF, 32'h1000 + k, "intlv wr");
        end
        for (int k = 0; k < 16; k++) begin
            issue(0, 1'b1, `TCDM_INTLV_BASE + 4 * k, 4'hF, 0, "intlv rd");
        end
        // Both contiguous windows, with partial byte enables
        for (int s = 0; s < 2; s++) begin
            issue(1, 1'b0, `TCDM_CONTIG_BASE + s * `TCDM_CONTIG_SIZE + 8, 4'hF,
                  32'h1122_3344, "contig wr");
            issue(1, 1'b0, `TCDM_CONTIG_BASE + s * `TCDM_CONTIG_SIZE + 8, 4'b0101,
                  32'hAABB_CCDD, "contig be");
            issue(1, 1'b1, `TCDM_CONTIG_BASE + s * `TCDM_CONTIG_SIZE + 8, 4'hF,
                  0, "contig rd");
        end
        only_one = 1'b1;
        issue(0, 1'b1, 32'h3000_0000, 4'hF, 0, "unmapped");
        issue(2, 1'b0, `TCDM_CONTIG_BASE, 4'hF, 32'h55, "restricted");
        only_one = 1'b0;
        fork
            hammer_bank(0);
            hammer_bank(1);
            hammer_bank(2);
        join
        stall_en = 1'b1;
        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join
        stall_en = 1'b0;
        repeat (3) @(negedge clk_i);
        if (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
            $display("Some requests never received their response");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
